// File: source/hart_csr_pkg.sv
`default_nettype none

package hart_csr_pkg;

  typedef logic [11:0] csr_addr_t;
  typedef logic [1:0] priv_t;
  typedef logic [63:0] mtime_t;
  typedef logic [3:0] clint_addr_t;
  typedef logic [31:0] clint_data_t;
  // One bit per interrupt source, same layout in mip and mie
  typedef logic [11:0] irq_vec_t;

  // Privilege levels
  localparam priv_t PRIV_U = 2'd0;
  localparam priv_t PRIV_S = 2'd1;
  localparam priv_t PRIV_RSVD = 2'd2;
  localparam priv_t PRIV_M = 2'd3;

  localparam csr_addr_t CSR_SSTATUS = 12'h100;
  localparam csr_addr_t CSR_SIE = 12'h104;
  localparam csr_addr_t CSR_SEPC = 12'h141;
  localparam csr_addr_t CSR_SCAUSE = 12'h142;
  localparam csr_addr_t CSR_SIP = 12'h144;
  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MIE = 12'h304;
  localparam csr_addr_t CSR_MEPC = 12'h341;
  localparam csr_addr_t CSR_MCAUSE = 12'h342;
  localparam csr_addr_t CSR_MIP = 12'h344;

  // mstatus fields
  localparam int STATUS_SIE = 1;
  localparam int STATUS_MIE = 3;
  localparam int STATUS_SPIE = 5;
  localparam int STATUS_MPIE = 7;
  localparam int STATUS_SPP = 8;
  localparam int STATUS_MPP_LO = 11;
  localparam int STATUS_MPP_HI = 12;
  localparam int STATUS_MPRV = 17;

  // Interrupt bits, also the interrupt cause codes
  localparam int IRQ_SSI = 1;
  localparam int IRQ_MSI = 3;
  localparam int IRQ_STI = 5;
  localparam int IRQ_MTI = 7;
  localparam int IRQ_SEI = 9;
  localparam int IRQ_MEI = 11;
  localparam irq_vec_t IRQ_WRITABLE = 12'haaa;
  localparam irq_vec_t IRQ_S_LEVEL = 12'h222;

  localparam int CAUSE_ILLEGAL = 2;
  // ECALL cause is the base plus the privilege it came from
  localparam int CAUSE_ECALL_BASE = 8;

  // CLINT word map
  localparam clint_addr_t CLINT_MSIP = 4'd0;
  localparam clint_addr_t CLINT_SSIP = 4'd1;
  localparam clint_addr_t CLINT_MTIMECMP_LO = 4'd2;
  localparam clint_addr_t CLINT_MTIMECMP_HI = 4'd3;
  localparam clint_addr_t CLINT_MTIME_LO = 4'd4;
  localparam clint_addr_t CLINT_MTIME_HI = 4'd5;

endpackage

`default_nettype wire

// File: source/trap_if.sv
`timescale 1ns/1ps
`default_nettype none

interface trap_if #(
  parameter int XLEN = 32
);

  // Interrupt state published by the CSR file
  hart_csr_pkg::irq_vec_t mip;
  hart_csr_pkg::irq_vec_t mie;
  hart_csr_pkg::priv_t priv;
  logic mstatus_mie;
  logic mstatus_sie;

  // Selector verdict, code sized for the mcause code field
  logic irq_take;
  logic [$clog2(XLEN)-1:0] irq_code;

  modport csr (
    output mip, mie, priv, mstatus_mie, mstatus_sie,
    input irq_take, irq_code
  );

  modport sel (
    input mip, mie, priv, mstatus_mie, mstatus_sie,
    output irq_take, irq_code
  );

endinterface

`default_nettype wire

// File: source/clint.sv
`timescale 1ns/1ps
`default_nettype none

module clint (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      bus_valid,
  output logic                      bus_ready,
  input  logic                      bus_write,
  input  hart_csr_pkg::clint_addr_t bus_addr,
  input  hart_csr_pkg::clint_data_t bus_wdata,
  output hart_csr_pkg::clint_data_t bus_rdata,
  output logic                      bus_rvalid,
  output logic                      msip,
  output logic                      ssip,
  output logic                      mtip
);

  hart_csr_pkg::mtime_t mtime;
  hart_csr_pkg::mtime_t mtimecmp;
  hart_csr_pkg::clint_data_t read_word;
  logic accept;
  logic wr_en;
  logic rd_en;

  // Busy while a read response is on the bus
  assign bus_ready = !bus_rvalid;
  assign accept = bus_valid && bus_ready;
  assign wr_en = accept && bus_write;
  assign rd_en = accept && !bus_write;

  // Free-running timer, a write to either half replaces that half
  always_ff @(posedge clock) begin
    if (reset) begin
      mtime <= '0;
    end else if (wr_en && bus_addr == hart_csr_pkg::CLINT_MTIME_LO) begin
      mtime <= {mtime[63:32], bus_wdata};
    end else if (wr_en && bus_addr == hart_csr_pkg::CLINT_MTIME_HI) begin
      mtime <= {bus_wdata, mtime[31:0]};
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  // All ones keeps the timer quiet until software arms it
  always_ff @(posedge clock) begin
    if (reset) begin
      mtimecmp <= '1;
    end else if (wr_en && bus_addr == hart_csr_pkg::CLINT_MTIMECMP_LO) begin
      mtimecmp <= {mtimecmp[63:32], bus_wdata};
    end else if (wr_en && bus_addr == hart_csr_pkg::CLINT_MTIMECMP_HI) begin
      mtimecmp <= {bus_wdata, mtimecmp[31:0]};
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      msip <= 1'b0;
      ssip <= 1'b0;
    end else if (wr_en) begin
      if (bus_addr == hart_csr_pkg::CLINT_MSIP) msip <= bus_wdata[0];
      if (bus_addr == hart_csr_pkg::CLINT_SSIP) ssip <= bus_wdata[0];
    end
  end

  always_comb begin
    case (bus_addr)
      hart_csr_pkg::CLINT_MSIP:        read_word = {31'd0, msip};
      hart_csr_pkg::CLINT_SSIP:        read_word = {31'd0, ssip};
      hart_csr_pkg::CLINT_MTIMECMP_LO: read_word = mtimecmp[31:0];
      hart_csr_pkg::CLINT_MTIMECMP_HI: read_word = mtimecmp[63:32];
      hart_csr_pkg::CLINT_MTIME_LO:    read_word = mtime[31:0];
      hart_csr_pkg::CLINT_MTIME_HI:    read_word = mtime[63:32];
      default:                         read_word = '0;
    endcase
  end

  // One-cycle read response
  always_ff @(posedge clock) begin
    if (rd_en) bus_rdata <= read_word;
  end

  always_ff @(posedge clock) begin
    if (reset) bus_rvalid <= 1'b0;
    else bus_rvalid <= rd_en;
  end

  assign mtip = mtime >= mtimecmp;

endmodule

`default_nettype wire

// File: source/interrupt_select.sv
`timescale 1ns/1ps
`default_nettype none

module interrupt_select #(
  parameter int XLEN = 32
) (
  trap_if.sel tif
);

  localparam int CW = $clog2(XLEN);

  hart_csr_pkg::irq_vec_t pending;
  hart_csr_pkg::irq_vec_t level_ok;
  hart_csr_pkg::irq_vec_t armed;
  logic m_allow;
  logic s_allow;

  assign pending = tif.mip & tif.mie;

  // M-level sources fire below M, or in M with MIE set
  assign m_allow = (tif.priv != hart_csr_pkg::PRIV_M) || tif.mstatus_mie;
  // S-level sources never fire in M since nothing is delegated
  assign s_allow = (tif.priv == hart_csr_pkg::PRIV_U) ||
                   (tif.priv == hart_csr_pkg::PRIV_S && tif.mstatus_sie);

  always_comb begin
    level_ok = '0;
    level_ok[hart_csr_pkg::IRQ_MEI] = m_allow;
    level_ok[hart_csr_pkg::IRQ_MSI] = m_allow;
    level_ok[hart_csr_pkg::IRQ_MTI] = m_allow;
    level_ok[hart_csr_pkg::IRQ_SEI] = s_allow;
    level_ok[hart_csr_pkg::IRQ_SSI] = s_allow;
    level_ok[hart_csr_pkg::IRQ_STI] = s_allow;
  end

  assign armed = pending & level_ok;

  // Fixed priority MEI, MSI, MTI, SEI, SSI, STI
  always_comb begin
    tif.irq_take = 1'b1;
    tif.irq_code = '0;
    if (armed[hart_csr_pkg::IRQ_MEI]) begin
      tif.irq_code = CW'(hart_csr_pkg::IRQ_MEI);
    end else if (armed[hart_csr_pkg::IRQ_MSI]) begin
      tif.irq_code = CW'(hart_csr_pkg::IRQ_MSI);
    end else if (armed[hart_csr_pkg::IRQ_MTI]) begin
      tif.irq_code = CW'(hart_csr_pkg::IRQ_MTI);
    end else if (armed[hart_csr_pkg::IRQ_SEI]) begin
      tif.irq_code = CW'(hart_csr_pkg::IRQ_SEI);
    end else if (armed[hart_csr_pkg::IRQ_SSI]) begin
      tif.irq_code = CW'(hart_csr_pkg::IRQ_SSI);
    end else if (armed[hart_csr_pkg::IRQ_STI]) begin
      tif.irq_code = CW'(hart_csr_pkg::IRQ_STI);
    end else begin
      tif.irq_take = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: source/csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file #(
  parameter int XLEN = 32
) (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    csr_valid,
  output logic                    csr_ready,
  input  logic                    csr_write,
  input  hart_csr_pkg::csr_addr_t csr_addr,
  input  logic [XLEN-1:0]         csr_wdata,
  output logic [XLEN-1:0]         csr_rdata,
  input  logic [XLEN-1:0]         pc,
  input  logic                    illegal_instr,
  input  logic                    ecall,
  input  logic                    mret,
  input  logic                    sret,
  input  logic                    msip,
  input  logic                    ssip,
  input  logic                    mtip,
  input  logic                    ext_irq,
  output logic                    trap,
  output logic [XLEN-1:0]         trap_cause,
  output logic [XLEN-1:0]         mepc,
  output logic [XLEN-1:0]         sepc,
  output hart_csr_pkg::priv_t     priv_mode,
  trap_if.csr                     tif
);

  localparam int CW = $clog2(XLEN);

  // mstatus fields
  logic st_sie;
  logic st_mie;
  logic st_spie;
  logic st_mpie;
  logic st_spp;
  logic st_mprv;
  hart_csr_pkg::priv_t st_mpp;
  hart_csr_pkg::priv_t wr_mpp;

  hart_csr_pkg::irq_vec_t mie_en;
  hart_csr_pkg::irq_vec_t mip_view;
  logic seip;
  logic stip;
  logic [XLEN-1:0] mcause;
  logic [XLEN-1:0] scause;
  logic [XLEN-1:0] mstatus_view;
  logic [XLEN-1:0] sstatus_view;
  logic [XLEN-1:0] trap_code;
  logic csr_we;

  // WARL check for mcause and scause
  function automatic logic cause_legal(input logic [XLEN-1:0] value);
    logic [XLEN-2:0] code;
    logic legal;
    code = value[XLEN-2:0];
    if (value[XLEN-1]) begin
      legal = code[0] && code <= hart_csr_pkg::IRQ_MEI;
    end else begin
      legal = code == hart_csr_pkg::CAUSE_ILLEGAL ||
              code == hart_csr_pkg::CAUSE_ECALL_BASE + hart_csr_pkg::PRIV_U ||
              code == hart_csr_pkg::CAUSE_ECALL_BASE + hart_csr_pkg::PRIV_S ||
              code == hart_csr_pkg::CAUSE_ECALL_BASE + hart_csr_pkg::PRIV_M;
    end
    return legal;
  endfunction

  function automatic logic [XLEN-1:0] irq_word(input hart_csr_pkg::irq_vec_t bits);
    return {{(XLEN-12){1'b0}}, bits};
  endfunction

  // Interrupts first, then illegal, then ecall
  assign trap = tif.irq_take || illegal_instr || ecall;
  always_comb begin
    if (tif.irq_take) begin
      trap_code = {1'b1, {(XLEN-1-CW){1'b0}}, tif.irq_code};
    end else if (illegal_instr) begin
      trap_code = XLEN'(hart_csr_pkg::CAUSE_ILLEGAL);
    end else begin
      trap_code = XLEN'(hart_csr_pkg::CAUSE_ECALL_BASE) | XLEN'(priv_mode);
    end
  end
  // Outside a trap cycle this shows the last recorded cause
  assign trap_cause = trap ? trap_code : mcause;

  // Accesses stall while a trap or return owns the state
  assign csr_ready = !(trap || mret || sret);
  assign csr_we = csr_valid && csr_ready && csr_write;
  assign wr_mpp = csr_wdata[hart_csr_pkg::STATUS_MPP_HI:hart_csr_pkg::STATUS_MPP_LO];

  always_ff @(posedge clock) begin
    if (reset) begin
      st_sie <= 1'b0;
      st_mie <= 1'b0;
      st_spie <= 1'b0;
      st_mpie <= 1'b0;
      st_spp <= 1'b0;
      st_mprv <= 1'b0;
      st_mpp <= hart_csr_pkg::PRIV_U;
    end else if (trap) begin
      st_mpie <= st_mie;
      st_mie <= 1'b0;
      st_mpp <= priv_mode;
    end else if (mret) begin
      st_mie <= st_mpie;
      st_mpie <= 1'b1;
      st_mpp <= hart_csr_pkg::PRIV_M;
      if (st_mpp != hart_csr_pkg::PRIV_M) st_mprv <= 1'b0;
    end else if (sret) begin
      st_sie <= st_spie;
      st_spie <= 1'b1;
      st_spp <= 1'b1;
      st_mprv <= 1'b0;
    end else if (csr_we && csr_addr == hart_csr_pkg::CSR_MSTATUS) begin
      st_sie <= csr_wdata[hart_csr_pkg::STATUS_SIE];
      st_mie <= csr_wdata[hart_csr_pkg::STATUS_MIE];
      st_spie <= csr_wdata[hart_csr_pkg::STATUS_SPIE];
      st_mpie <= csr_wdata[hart_csr_pkg::STATUS_MPIE];
      st_spp <= csr_wdata[hart_csr_pkg::STATUS_SPP];
      st_mprv <= csr_wdata[hart_csr_pkg::STATUS_MPRV];
      if (wr_mpp != hart_csr_pkg::PRIV_RSVD) st_mpp <= wr_mpp;
    end else if (csr_we && csr_addr == hart_csr_pkg::CSR_SSTATUS) begin
      st_sie <= csr_wdata[hart_csr_pkg::STATUS_SIE];
      st_spie <= csr_wdata[hart_csr_pkg::STATUS_SPIE];
      st_spp <= csr_wdata[hart_csr_pkg::STATUS_SPP];
    end
  end

  // Every trap lands in M
  always_ff @(posedge clock) begin
    if (reset) priv_mode <= hart_csr_pkg::PRIV_M;
    else if (trap) priv_mode <= hart_csr_pkg::PRIV_M;
    else if (mret) priv_mode <= st_mpp;
    else if (sret) priv_mode <= {1'b0, st_spp};
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mie_en <= '0;
    end else if (csr_we && csr_addr == hart_csr_pkg::CSR_MIE) begin
      mie_en <= csr_wdata[11:0] & hart_csr_pkg::IRQ_WRITABLE;
    end else if (csr_we && csr_addr == hart_csr_pkg::CSR_SIE) begin
      mie_en <= (mie_en & ~hart_csr_pkg::IRQ_S_LEVEL) |
                (csr_wdata[11:0] & hart_csr_pkg::IRQ_S_LEVEL);
    end
  end

  // SEI and STI are raised by M-mode software only
  always_ff @(posedge clock) begin
    if (reset) begin
      seip <= 1'b0;
      stip <= 1'b0;
    end else if (csr_we && priv_mode == hart_csr_pkg::PRIV_M &&
                 (csr_addr == hart_csr_pkg::CSR_MIP || csr_addr == hart_csr_pkg::CSR_SIP)) begin
      seip <= csr_wdata[hart_csr_pkg::IRQ_SEI];
      stip <= csr_wdata[hart_csr_pkg::IRQ_STI];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mepc <= '0;
      mcause <= '0;
    end else if (trap) begin
      mepc <= pc;
      mcause <= trap_code;
    end else begin
      if (csr_we && csr_addr == hart_csr_pkg::CSR_MEPC) mepc <= {csr_wdata[XLEN-1:2], 2'b00};
      if (csr_we && csr_addr == hart_csr_pkg::CSR_MCAUSE && cause_legal(csr_wdata)) begin
        mcause <= csr_wdata;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      sepc <= '0;
      scause <= '0;
    end else begin
      if (csr_we && csr_addr == hart_csr_pkg::CSR_SEPC) sepc <= {csr_wdata[XLEN-1:2], 2'b00};
      if (csr_we && csr_addr == hart_csr_pkg::CSR_SCAUSE && cause_legal(csr_wdata)) begin
        scause <= csr_wdata;
      end
    end
  end

  always_comb begin
    mip_view = '0;
    mip_view[hart_csr_pkg::IRQ_SSI] = ssip;
    mip_view[hart_csr_pkg::IRQ_MSI] = msip;
    mip_view[hart_csr_pkg::IRQ_STI] = stip;
    mip_view[hart_csr_pkg::IRQ_MTI] = mtip;
    mip_view[hart_csr_pkg::IRQ_SEI] = seip;
    mip_view[hart_csr_pkg::IRQ_MEI] = ext_irq;
  end

  always_comb begin
    mstatus_view = '0;
    mstatus_view[hart_csr_pkg::STATUS_SIE] = st_sie;
    mstatus_view[hart_csr_pkg::STATUS_MIE] = st_mie;
    mstatus_view[hart_csr_pkg::STATUS_SPIE] = st_spie;
    mstatus_view[hart_csr_pkg::STATUS_MPIE] = st_mpie;
    mstatus_view[hart_csr_pkg::STATUS_SPP] = st_spp;
    mstatus_view[hart_csr_pkg::STATUS_MPP_HI:hart_csr_pkg::STATUS_MPP_LO] = st_mpp;
    mstatus_view[hart_csr_pkg::STATUS_MPRV] = st_mprv;
    // S view keeps only the S fields
    sstatus_view = '0;
    sstatus_view[hart_csr_pkg::STATUS_SIE] = st_sie;
    sstatus_view[hart_csr_pkg::STATUS_SPIE] = st_spie;
    sstatus_view[hart_csr_pkg::STATUS_SPP] = st_spp;
  end

  always_comb begin
    case (csr_addr)
      hart_csr_pkg::CSR_SSTATUS: csr_rdata = sstatus_view;
      hart_csr_pkg::CSR_SIE:     csr_rdata = irq_word(mie_en & hart_csr_pkg::IRQ_S_LEVEL);
      hart_csr_pkg::CSR_SEPC:    csr_rdata = sepc;
      hart_csr_pkg::CSR_SCAUSE:  csr_rdata = scause;
      hart_csr_pkg::CSR_SIP:     csr_rdata = irq_word(mip_view & hart_csr_pkg::IRQ_S_LEVEL);
      hart_csr_pkg::CSR_MSTATUS: csr_rdata = mstatus_view;
      hart_csr_pkg::CSR_MIE:     csr_rdata = irq_word(mie_en);
      hart_csr_pkg::CSR_MEPC:    csr_rdata = mepc;
      hart_csr_pkg::CSR_MCAUSE:  csr_rdata = mcause;
      hart_csr_pkg::CSR_MIP:     csr_rdata = irq_word(mip_view);
      default:                   csr_rdata = '0;
    endcase
  end

  assign tif.mip = mip_view;
  assign tif.mie = mie_en;
  assign tif.priv = priv_mode;
  assign tif.mstatus_mie = st_mie;
  assign tif.mstatus_sie = st_sie;

endmodule

`default_nettype wire

// File: source/hart_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module hart_ctrl_top #(
  parameter int XLEN = 32
) (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      csr_valid,
  output logic                      csr_ready,
  input  logic                      csr_write,
  input  hart_csr_pkg::csr_addr_t   csr_addr,
  input  logic [XLEN-1:0]           csr_wdata,
  output logic [XLEN-1:0]           csr_rdata,
  input  logic [XLEN-1:0]           pc,
  input  logic                      illegal_instr,
  input  logic                      ecall,
  input  logic                      mret,
  input  logic                      sret,
  input  logic                      ext_irq,
  input  logic                      clint_valid,
  output logic                      clint_ready,
  input  logic                      clint_write,
  input  hart_csr_pkg::clint_addr_t clint_addr,
  input  hart_csr_pkg::clint_data_t clint_wdata,
  output hart_csr_pkg::clint_data_t clint_rdata,
  output logic                      clint_rvalid,
  output logic                      trap,
  output logic [XLEN-1:0]           trap_cause,
  output logic [XLEN-1:0]           mepc,
  output logic [XLEN-1:0]           sepc,
  output hart_csr_pkg::priv_t       priv_mode
);

  // Interrupt lines from the CLINT
  logic msip;
  logic ssip;
  logic mtip;

  trap_if #(.XLEN(XLEN)) tif ();

  clint u_clint (
    .clock      (clock),
    .reset      (reset),
    .bus_valid  (clint_valid),
    .bus_ready  (clint_ready),
    .bus_write  (clint_write),
    .bus_addr   (clint_addr),
    .bus_wdata  (clint_wdata),
    .bus_rdata  (clint_rdata),
    .bus_rvalid (clint_rvalid),
    .msip       (msip),
    .ssip       (ssip),
    .mtip       (mtip)
  );

  interrupt_select #(.XLEN(XLEN)) u_select (
    .tif (tif.sel)
  );

  csr_file #(.XLEN(XLEN)) u_csr (
    .clock         (clock),
    .reset         (reset),
    .csr_valid     (csr_valid),
    .csr_ready     (csr_ready),
    .csr_write     (csr_write),
    .csr_addr      (csr_addr),
    .csr_wdata     (csr_wdata),
    .csr_rdata     (csr_rdata),
    .pc            (pc),
    .illegal_instr (illegal_instr),
    .ecall         (ecall),
    .mret          (mret),
    .sret          (sret),
    .msip          (msip),
    .ssip          (ssip),
    .mtip          (mtip),
    .ext_irq       (ext_irq),
    .trap          (trap),
    .trap_cause    (trap_cause),
    .mepc          (mepc),
    .sepc          (sepc),
    .priv_mode     (priv_mode),
    .tif           (tif.csr)
  );

endmodule

`default_nettype wire

// File: verif/csr_ref_model.svh
`ifndef CSR_REF_MODEL_SVH
`define CSR_REF_MODEL_SVH

// Expected CSR state for an XLEN of 32
logic ref_sie;
logic ref_mie;
logic ref_spie;
logic ref_mpie;
logic ref_spp;
logic ref_mprv;
logic [1:0] ref_mpp;
logic [1:0] ref_priv;
logic [11:0] ref_ien;
logic ref_seip;
logic ref_stip;
logic ref_msip;
logic ref_ssip;
logic ref_ext;
logic ref_mtip;
logic [31:0] ref_mepc;
logic [31:0] ref_sepc;
logic [31:0] ref_mcause;
logic [31:0] ref_scause;

task automatic clear_model();
  {ref_sie, ref_mie, ref_spie, ref_mpie, ref_spp, ref_mprv} = '0;
  ref_mpp = 2'd0;
  ref_priv = 2'd3;
  ref_ien = '0;
  {ref_seip, ref_stip, ref_msip, ref_ssip, ref_ext, ref_mtip} = '0;
  ref_mepc = '0;
  ref_sepc = '0;
  ref_mcause = '0;
  ref_scause = '0;
endtask

function automatic logic [31:0] status_word();
  logic [31:0] w;
  w = '0;
  w[1] = ref_sie;
  w[3] = ref_mie;
  w[5] = ref_spie;
  w[7] = ref_mpie;
  w[8] = ref_spp;
  w[12:11] = ref_mpp;
  w[17] = ref_mprv;
  return w;
endfunction

function automatic logic [11:0] pending_word();
  logic [11:0] w;
  w = '0;
  w[1] = ref_ssip;
  w[3] = ref_msip;
  w[5] = ref_stip;
  w[7] = ref_mtip;
  w[9] = ref_seip;
  w[11] = ref_ext;
  return w;
endfunction

// Odd interrupt codes up to 11 and exception codes 2, 8, 9 and 11
function automatic logic legal_cause(input logic [31:0] v);
  logic [30:0] code;
  code = v[30:0];
  if (v[31]) return code[0] && code <= 31'd11;
  return code == 31'd2 || code == 31'd8 || code == 31'd9 || code == 31'd11;
endfunction

function automatic logic [31:0] expect_read(input logic [11:0] addr);
  case (addr)
    hart_csr_pkg::CSR_SSTATUS: return status_word() & 32'h122;
    hart_csr_pkg::CSR_SIE:     return {20'd0, ref_ien & 12'h222};
    hart_csr_pkg::CSR_SEPC:    return ref_sepc;
    hart_csr_pkg::CSR_SCAUSE:  return ref_scause;
    hart_csr_pkg::CSR_SIP:     return {20'd0, pending_word() & 12'h222};
    hart_csr_pkg::CSR_MSTATUS: return status_word();
    hart_csr_pkg::CSR_MIE:     return {20'd0, ref_ien};
    hart_csr_pkg::CSR_MEPC:    return ref_mepc;
    hart_csr_pkg::CSR_MCAUSE:  return ref_mcause;
    hart_csr_pkg::CSR_MIP:     return {20'd0, pending_word()};
    default:                   return '0;
  endcase
endfunction

task automatic predict_write(input logic [11:0] addr, input logic [31:0] d);
  case (addr)
    hart_csr_pkg::CSR_MSTATUS: begin
      {ref_sie, ref_mie, ref_spie, ref_mpie} = {d[1], d[3], d[5], d[7]};
      ref_spp = d[8];
      ref_mprv = d[17];
      if (d[12:11] != 2'd2) ref_mpp = d[12:11];
    end
    hart_csr_pkg::CSR_SSTATUS: {ref_sie, ref_spie, ref_spp} = {d[1], d[5], d[8]};
    hart_csr_pkg::CSR_MIE: ref_ien = d[11:0] & 12'haaa;
    hart_csr_pkg::CSR_SIE: ref_ien = (ref_ien & ~12'h222) | (d[11:0] & 12'h222);
    hart_csr_pkg::CSR_MIP, hart_csr_pkg::CSR_SIP: begin
      if (ref_priv == 2'd3) {ref_seip, ref_stip} = {d[9], d[5]};
    end
    hart_csr_pkg::CSR_MEPC: ref_mepc = d & ~32'd3;
    hart_csr_pkg::CSR_SEPC: ref_sepc = d & ~32'd3;
    hart_csr_pkg::CSR_MCAUSE: if (legal_cause(d)) ref_mcause = d;
    hart_csr_pkg::CSR_SCAUSE: if (legal_cause(d)) ref_scause = d;
    default: ;
  endcase
endtask

task automatic enter_trap(input logic [31:0] cause, input logic [31:0] pc_val);
  ref_mcause = cause;
  ref_mepc = pc_val;
  ref_mpie = ref_mie;
  ref_mie = 1'b0;
  ref_mpp = ref_priv;
  ref_priv = 2'd3;
endtask

task automatic return_m();
  ref_mie = ref_mpie;
  ref_mpie = 1'b1;
  if (ref_mpp != 2'd3) ref_mprv = 1'b0;
  ref_priv = ref_mpp;
  ref_mpp = 2'd3;
endtask

task automatic return_s();
  ref_sie = ref_spie;
  ref_spie = 1'b1;
  ref_priv = {1'b0, ref_spp};
  ref_spp = 1'b1;
  ref_mprv = 1'b0;
endtask

// Order MEI, MSI, MTI, SEI, SSI, STI with M and S gating
task automatic select_irq(output logic take, output logic [3:0] code);
  logic [11:0] armed;
  logic m_ok;
  logic s_ok;
  int order[6];
  order = '{11, 3, 7, 9, 1, 5};
  m_ok = ref_priv != 2'd3 || ref_mie;
  s_ok = ref_priv == 2'd0 || (ref_priv == 2'd1 && ref_sie);
  armed = pending_word() & ref_ien;
  armed = armed & ({12{m_ok}} & 12'h888 | {12{s_ok}} & 12'h222);
  take = 1'b0;
  code = '0;
  foreach (order[k]) begin
    if (!take && armed[order[k]]) begin
      take = 1'b1;
      code = 4'(order[k]);
    end
  end
endtask

`endif

// File: verif/tb_hart_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_hart_ctrl;

  localparam int XLEN = 32;
  localparam int N_RW = 200;
  localparam int N_SYNC = 100;
  localparam int N_RET = 100;
  localparam int N_PRIO = 150;
  localparam int N_BP = 50;
  localparam int N_TIMER = 1;
  // Cycle bound per iteration covering the timer wait
  localparam int ITER_CYCLES = 400;

  logic clock;
  logic reset;
  logic csr_valid;
  logic csr_ready;
  logic csr_write;
  hart_csr_pkg::csr_addr_t csr_addr;
  logic [XLEN-1:0] csr_wdata;
  logic [XLEN-1:0] csr_rdata;
  logic [XLEN-1:0] pc;
  logic illegal_instr;
  logic ecall;
  logic mret;
  logic sret;
  logic ext_irq;
  logic clint_valid;
  logic clint_ready;
  logic clint_write;
  hart_csr_pkg::clint_addr_t clint_addr;
  hart_csr_pkg::clint_data_t clint_wdata;
  hart_csr_pkg::clint_data_t clint_rdata;
  logic clint_rvalid;
  logic trap;
  logic [XLEN-1:0] trap_cause;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] sepc;
  hart_csr_pkg::priv_t priv_mode;

  int errors;
  int checks;

  `include "csr_ref_model.svh"

  hart_ctrl_top #(.XLEN(XLEN)) dut_i (.*);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  initial begin
    repeat ((N_RW + N_SYNC + N_RET + N_PRIO + N_BP + N_TIMER) * ITER_CYCLES) @(posedge clock);
    $display("Timeout: the run did not finish within its cycle bound");
    $display("*** FAILED ***");
    $finish;
  end

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("ERR %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_true(input string what, input logic cond);
    checks++;
    assert (cond === 1'b1) else begin
      errors++;
      $display("Check failed: %s", what);
    end
  endtask

  // Starts and ends just after a falling edge
  task automatic csr_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] data,
                          output logic [31:0] rd);
    csr_valid = 1'b1;
    csr_write = wr;
    csr_addr = addr;
    csr_wdata = data;
    #1;
    while (!csr_ready) begin
      @(negedge clock);
      #1;
    end
    rd = csr_rdata;
    @(posedge clock);
    if (wr) predict_write(addr, data);
    @(negedge clock);
    csr_valid = 1'b0;
    csr_write = 1'b0;
  endtask

  task automatic csr_set(input logic [11:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    csr_xfer(1'b1, addr, data, rd);
  endtask

  task automatic read_check(input string name, input logic [11:0] addr);
    logic [31:0] rd;
    csr_xfer(1'b0, addr, '0, rd);
    check_val(name, expect_read(addr), rd);
  endtask

  task automatic clint_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] data,
                            output logic [31:0] rd);
    clint_valid = 1'b1;
    clint_write = wr;
    clint_addr = addr;
    clint_wdata = data;
    #1;
    while (!clint_ready) begin
      @(negedge clock);
      #1;
    end
    @(posedge clock);
    @(negedge clock);
    clint_valid = 1'b0;
    clint_write = 1'b0;
    rd = '0;
    if (!wr) begin
      check_true("CLINT read response missing", clint_rvalid);
      rd = clint_rdata;
    end
  endtask

  // Kind 0 illegal, 1 ecall, 2 mret, 3 sret, 4 idle cycle
  task automatic pulse_event(input int kind);
    logic [31:0] pc_val;
    logic take;
    logic [3:0] code;
    logic [31:0] exp_cause;
    logic traps;
    pc_val = $urandom & 32'hffff_fffc;
    select_irq(take, code);
    traps = take || kind < 2;
    pc = pc_val;
    illegal_instr = kind == 0;
    ecall = kind == 1;
    mret = kind == 2;
    sret = kind == 3;
    #1;
    if (take) exp_cause = 32'h8000_0000 | 32'(code);
    else if (kind == 0) exp_cause = 32'd2;
    else exp_cause = 32'd8 + 32'(ref_priv);
    check_val("trap_flag", {31'd0, traps}, {31'd0, trap});
    if (traps) check_val("trap_cause", exp_cause, trap_cause);
    @(posedge clock);
    if (traps) enter_trap(exp_cause, pc_val);
    else if (kind == 2) return_m();
    else if (kind == 3) return_s();
    @(negedge clock);
    {illegal_instr, ecall, mret, sret} = '0;
  endtask

  task automatic enter_priv(input logic [1:0] p);
    logic [31:0] w;
    w = status_word() & ~32'h0000_1808;
    w = w | {19'd0, p, 11'd0};
    csr_set(hart_csr_pkg::CSR_MSTATUS, w);
    pulse_event(2);
  endtask

  task automatic state_check(input string name);
    check_val({name, " priv"}, {30'd0, ref_priv}, {30'd0, priv_mode});
    check_val({name, " mepc"}, ref_mepc, mepc);
    check_val({name, " sepc"}, ref_sepc, sepc);
    read_check({name, " mstatus"}, hart_csr_pkg::CSR_MSTATUS);
    read_check({name, " mcause"}, hart_csr_pkg::CSR_MCAUSE);
  endtask

  initial begin
    logic [11:0] addr_list[11];
    logic [31:0] legal_list[4];
    logic [31:0] rd;
    logic [31:0] t0;
    logic [31:0] wd;
    logic [11:0] a;
    logic [1:0] p;
    int kind;
    addr_list = '{12'h100, 12'h104, 12'h141, 12'h142, 12'h144,
                  12'h300, 12'h304, 12'h341, 12'h342, 12'h344, 12'h7c0};
    legal_list = '{32'd2, 32'd9, 32'h8000_0007, 32'h8000_000b};
    void'($urandom(51));
    errors = 0;
    checks = 0;
    clear_model();
    reset = 1'b1;
    {csr_valid, csr_write, illegal_instr, ecall, mret, sret, ext_irq} = '0;
    {clint_valid, clint_write} = '0;
    csr_addr = '0;
    csr_wdata = '0;
    pc = '0;
    clint_addr = '0;
    clint_wdata = '0;
    repeat (16) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    #1;
    check_true("trap or handshake outputs wrong after reset",
               !trap && csr_ready && clint_ready && !clint_rvalid);
    state_check("reset");

    // CSR masking and WARL
    for (int i = 0; i < N_RW; i++) begin
      a = addr_list[$urandom % 11];
      wd = $urandom;
      if ((a == 12'h342 || a == 12'h142) && $urandom % 2) wd = legal_list[$urandom % 4];
      if (a == 12'h300 && $urandom % 4 == 0) wd[12:11] = 2'd2;
      csr_set(a, wd);
      read_check("csr_rw", a);
    end

    // Synchronous traps from random modes
    csr_set(hart_csr_pkg::CSR_MIE, '0);
    for (int i = 0; i < N_SYNC; i++) begin
      p = $urandom % 3;
      enter_priv(p == 2'd2 ? 2'd3 : p);
      pulse_event($urandom % 2);
      state_check("sync_trap");
    end

    // Returns
    for (int i = 0; i < N_RET; i++) begin
      csr_set(hart_csr_pkg::CSR_MSTATUS, $urandom);
      pulse_event(2 + $urandom % 2);
      state_check("return");
      if (ref_priv != 2'd3) pulse_event(1);
    end

    // Timer interrupt through the CLINT
    csr_set(hart_csr_pkg::CSR_MIE, 32'h80);
    csr_set(hart_csr_pkg::CSR_MSTATUS, 32'h8);
    clint_xfer(1'b0, hart_csr_pkg::CLINT_MTIME_LO, '0, t0);
    clint_xfer(1'b1, hart_csr_pkg::CLINT_MTIMECMP_HI, '0, rd);
    clint_xfer(1'b1, hart_csr_pkg::CLINT_MTIMECMP_LO, t0 + 32'd300, rd);
    pc = 32'h0000_4000;
    #1;
    while (!trap) begin
      @(negedge clock);
      #1;
    end
    check_val("timer_cause", 32'h8000_0007, trap_cause);
    @(posedge clock);
    enter_trap(32'h8000_0007, 32'h0000_4000);
    @(negedge clock);
    clint_xfer(1'b0, hart_csr_pkg::CLINT_MTIME_LO, '0, rd);
    check_true("mtime below mtimecmp after timer trap", rd >= t0 + 32'd300);
    ref_mtip = 1'b1;
    read_check("timer_mip", hart_csr_pkg::CSR_MIP);
    clint_xfer(1'b1, hart_csr_pkg::CLINT_MTIMECMP_LO, '1, rd);
    clint_xfer(1'b1, hart_csr_pkg::CLINT_MTIMECMP_HI, '1, rd);
    ref_mtip = 1'b0;
    csr_set(hart_csr_pkg::CSR_MIE, '0);
    state_check("timer");

    // Priority and enable gating
    for (int i = 0; i < N_PRIO; i++) begin
      csr_set(hart_csr_pkg::CSR_MSTATUS, status_word() & ~32'h8);
      csr_set(hart_csr_pkg::CSR_MIP, $urandom);
      ref_msip = $urandom % 2;
      ref_ssip = $urandom % 2;
      clint_xfer(1'b1, hart_csr_pkg::CLINT_MSIP, {31'd0, ref_msip}, rd);
      clint_xfer(1'b1, hart_csr_pkg::CLINT_SSIP, {31'd0, ref_ssip}, rd);
      ref_ext = $urandom % 2;
      ext_irq = ref_ext;
      p = $urandom % 3;
      wd = ($urandom & 32'h0000_00a2) | {19'd0, (p == 2'd2 ? 2'd3 : p), 11'd0};
      csr_set(hart_csr_pkg::CSR_MSTATUS, wd);
      csr_set(hart_csr_pkg::CSR_MIE, $urandom);
      pulse_event(2);
      pulse_event(4);
      state_check("priority");
      if (ref_priv != 2'd3) pulse_event(1);
      csr_set(hart_csr_pkg::CSR_MIE, '0);
      ref_ext = 1'b0;
      ext_irq = 1'b0;
    end
    ref_msip = 1'b0;
    ref_ssip = 1'b0;
    clint_xfer(1'b1, hart_csr_pkg::CLINT_MSIP, '0, rd);
    clint_xfer(1'b1, hart_csr_pkg::CLINT_SSIP, '0, rd);

    // CSR write held off by a trap or a return
    for (int i = 0; i < N_BP; i++) begin
      kind = $urandom % 2;
      a = kind ? 12'h300 : addr_list[2 + 5 * ($urandom % 2)];
      wd = $urandom;
      pc = $urandom & 32'hffff_fffc;
      t0 = 32'd8 + 32'(ref_priv);
      ecall = kind == 0;
      mret = kind == 1;
      csr_valid = 1'b1;
      csr_write = 1'b1;
      csr_addr = a;
      csr_wdata = wd;
      #1;
      check_true("csr_ready high during trap or return", !csr_ready);
      @(posedge clock);
      if (kind == 0) enter_trap(t0, pc);
      else return_m();
      @(negedge clock);
      ecall = 1'b0;
      mret = 1'b0;
      #1;
      check_true("csr_ready stuck low after trap or return", csr_ready);
      @(posedge clock);
      predict_write(a, wd);
      @(negedge clock);
      csr_valid = 1'b0;
      csr_write = 1'b0;
      read_check("backpressure", a);
      state_check("backpressure");
      if (ref_priv != 2'd3) pulse_event(1);
    end

    $display("Checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+verif
source/hart_csr_pkg.sv
source/trap_if.sv
source/clint.sv
source/interrupt_select.sv
source/csr_file.sv
source/hart_ctrl_top.sv
verif/tb_hart_ctrl.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_hart_ctrl
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal
PASS_STRING ?= \*\*\* PASSED \*\*\*

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_STRING)"

clean:
	rm -rf $(BUILD_DIR)
